// ==== hdl/mpmc_pkg.sv ====
package mpmc_pkg;

	// ====================
	// Sizes
	// ====================

	// Number of client ports, and so of command FIFOs
	localparam int NPORTS = 4;
	localparam int PORT_W = $clog2(NPORTS);

	// Memory word address and data widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// Command FIFO geometry; the count needs one more bit than the pointers
	localparam int FIFO_DEPTH = 4;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Cycles a FIFO stays busy once reset has been released
	localparam int RST_BUSY_CYCLES = 3;
	localparam int BUSY_W = $clog2(RST_BUSY_CYCLES + 1);

	// Words cleared by the calibration pass, starting at address zero
	localparam int CALIB_WORDS = 16;

	// ====================
	// Types
	// ====================

	typedef enum logic [2:0] {CALIB, IDLE, SETUP, ACCESS, RESP} mpmc_state_t;

	// One queued command, 1 + 8 + 32 = 41 bits
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mpmc_cmd_t;

endpackage

// ==== hdl/mpmc_fifo_if.sv ====
// Status, head and pop lines between the command FIFO bank and the controller
interface mpmc_fifo_if;

	// One bit per FIFO, high while the FIFO holds no command
	logic [mpmc_pkg::NPORTS-1:0] empty;

	// One bit per FIFO, high for a few cycles after reset
	logic [mpmc_pkg::NPORTS-1:0] rd_rst_busy;

	// Pop strobes from the controller, one-hot or zero
	logic [mpmc_pkg::NPORTS-1:0] pop;

	// Oldest entry of each FIFO, valid while its empty bit is low
	mpmc_pkg::mpmc_cmd_t head [mpmc_pkg::NPORTS];

	// The FIFO bank reports its state and consumes pops
	modport fifo_side (
		output empty,
		output rd_rst_busy,
		output head,
		input  pop
	);

	// The controller only reads heads and issues pops
	modport ctrl_side (
		input  head,
		output pop
	);

endinterface

// ==== hdl/mpmc_cmd_fifo.sv ====
module mpmc_cmd_fifo (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  mpmc_pkg::mpmc_cmd_t cmd,
	input  logic                pop,
	output mpmc_pkg::mpmc_cmd_t head,
	output logic                ready,
	output logic                empty,
	output logic                rd_rst_busy
);

	// Entry storage, written at wr_ptr and read at rd_ptr
	mpmc_pkg::mpmc_cmd_t mem [mpmc_pkg::FIFO_DEPTH];

	logic [mpmc_pkg::PTR_W-1:0]  wr_ptr;
	logic [mpmc_pkg::PTR_W-1:0]  rd_ptr;
	logic [mpmc_pkg::CNT_W-1:0]  count;
	logic [mpmc_pkg::CNT_W-1:0]  count_next;
	logic [mpmc_pkg::BUSY_W-1:0] busy_cnt;
	logic [mpmc_pkg::BUSY_W-1:0] busy_next;
	logic                        do_push;
	logic                        do_pop;

	// A command is taken only when the client sees ready
	assign do_push = push && ready;

	// Popping an empty FIFO is ignored so the count never wraps
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign rd_rst_busy = (busy_cnt != '0);
	assign head = mem[rd_ptr];

	// Next count and busy counter, shared by the state update and by ready
	always_comb
	begin
		count_next = count + mpmc_pkg::CNT_W'(do_push) - mpmc_pkg::CNT_W'(do_pop);
		if (busy_cnt != '0)
			busy_next = busy_cnt - mpmc_pkg::BUSY_W'(1);
		else
			busy_next = busy_cnt;
	end

	// ====================
	// Control state
	// ====================

	// Ready is registered from the next state, so it is already low
	// in the cycle the FIFO becomes full and stays low through reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			busy_cnt <= mpmc_pkg::BUSY_W'(mpmc_pkg::RST_BUSY_CYCLES);
			ready <= 1'b0;
		end
		else
		begin
			// Pointers wrap on their own because the depth is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			busy_cnt <= busy_next;
			ready <= (busy_next == '0) && (count_next != mpmc_pkg::CNT_W'(mpmc_pkg::FIFO_DEPTH));
		end
	end

	// Entry payload
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= cmd;
	end

endmodule

// ==== hdl/mpmc_rd_fifo_gen.sv ====
// Builds the vector of FIFOs the controller may serve next.
// The vector is registered, so it always trails the state by one cycle
module mpmc_rd_fifo_gen (
	input  logic                        clk,
	input  logic                        rst,
	input  mpmc_pkg::mpmc_state_t       state,
	input  logic [mpmc_pkg::NPORTS-1:0] empty,
	input  logic [mpmc_pkg::NPORTS-1:0] rd_rst_busy,
	input  logic                        calib_complete,
	output logic [mpmc_pkg::NPORTS-1:0] rd
);

	logic [mpmc_pkg::NPORTS-1:0] next_rd;

	// Only an idle controller gets candidates, and only after calibration
	always_comb
	begin
		next_rd = '0;
		if (state == mpmc_pkg::IDLE && calib_complete)
		begin
			for (int i = 0; i < mpmc_pkg::NPORTS; i++)
			begin
				// A FIFO still settling after reset is skipped even if it has data
				next_rd[i] = !empty[i] && !rd_rst_busy[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rd <= '0;
		else
			rd <= next_rd;
	end

endmodule

// ==== hdl/mpmc_port_sel.sv ====
module mpmc_port_sel (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mpmc_pkg::NPORTS-1:0] rd,
	input  logic                        take,
	output logic [mpmc_pkg::NPORTS-1:0] grant,
	output logic [mpmc_pkg::PORT_W-1:0] grant_idx
);

	// Index of the port served most recently
	logic [mpmc_pkg::PORT_W-1:0] last;

	// Round-robin search that starts one past the last served port.
	// The last served port itself is checked last, so it wins only when alone
	always_comb
	begin
		logic                        found;
		logic [mpmc_pkg::PORT_W-1:0] idx;
		found = 1'b0;
		grant = '0;
		grant_idx = '0;
		for (int k = 1; k <= mpmc_pkg::NPORTS; k++)
		begin
			// Wraps modulo NPORTS through truncation
			idx = mpmc_pkg::PORT_W'(int'(last) + k);
			if (!found && rd[idx])
			begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_idx = idx;
			end
		end
	end

	// Starting from the top index gives port 0 priority after reset
	always_ff @(posedge clk)
	begin
		if (rst)
			last <= mpmc_pkg::PORT_W'(mpmc_pkg::NPORTS - 1);
		else if (take)
			last <= grant_idx;
	end

endmodule

// ==== hdl/mpmc_ctrl.sv ====
module mpmc_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	mpmc_fifo_if.ctrl_side              fifo,
	input  logic [mpmc_pkg::NPORTS-1:0] rd,
	input  logic [mpmc_pkg::NPORTS-1:0] grant,
	input  logic [mpmc_pkg::PORT_W-1:0] grant_idx,
	output logic                        take,
	output mpmc_pkg::mpmc_state_t       state,
	output logic                        calib_complete,
	output logic [mpmc_pkg::ADDR_W-1:0] paddr,
	output logic                        psel,
	output logic                        penable,
	output logic                        pwrite,
	output logic [mpmc_pkg::DATA_W-1:0] pwdata,
	input  logic [mpmc_pkg::DATA_W-1:0] prdata,
	input  logic                        pready,
	input  logic                        pslverr,
	output logic [mpmc_pkg::NPORTS-1:0] rsp_valid,
	output logic [mpmc_pkg::DATA_W-1:0] rsp_data,
	output logic                        rsp_err
);

	// Next word to clear during calibration
	logic [mpmc_pkg::ADDR_W-1:0] calib_addr;

	// Command in flight and the port that issued it
	mpmc_pkg::mpmc_cmd_t         cur_cmd;
	logic [mpmc_pkg::PORT_W-1:0] cur_port;

	// High in the last cycle of an APB transfer
	logic xfer_done;

	// ====================
	// Outputs
	// ====================

	// The rd vector is zero whenever the controller has just come back to IDLE
	assign take = (state == mpmc_pkg::IDLE) && (rd != '0);
	assign fifo.pop = take ? grant : '0;

	// APB phases follow the state directly; the bus lines come from the latched command
	assign psel = (state == mpmc_pkg::SETUP) || (state == mpmc_pkg::ACCESS);
	assign penable = (state == mpmc_pkg::ACCESS);
	assign paddr = cur_cmd.addr;
	assign pwrite = cur_cmd.we;
	assign pwdata = cur_cmd.wdata;
	assign xfer_done = penable && pready;

	// One pulse on the issuing port's bit
	always_comb
	begin
		rsp_valid = '0;
		if (state == mpmc_pkg::RESP)
			rsp_valid[cur_port] = 1'b1;
	end

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= mpmc_pkg::CALIB;
			calib_complete <= 1'b0;
			calib_addr <= '0;
		end
		else
		begin
			case (state)
			mpmc_pkg::CALIB:
				state <= mpmc_pkg::SETUP;
			mpmc_pkg::IDLE:
				if (take)
					state <= mpmc_pkg::SETUP;
			mpmc_pkg::SETUP:
				state <= mpmc_pkg::ACCESS;
			mpmc_pkg::ACCESS:
				if (xfer_done)
				begin
					// Calibration writes loop back without a client response
					if (calib_complete)
						state <= mpmc_pkg::RESP;
					else if (calib_addr == mpmc_pkg::ADDR_W'(mpmc_pkg::CALIB_WORDS - 1))
					begin
						calib_complete <= 1'b1;
						state <= mpmc_pkg::IDLE;
					end
					else
					begin
						calib_addr <= calib_addr + 1'b1;
						state <= mpmc_pkg::CALIB;
					end
				end
			mpmc_pkg::RESP:
				state <= mpmc_pkg::IDLE;
			default:
				state <= mpmc_pkg::IDLE;
			endcase
		end
	end

	// Command latch and response capture
	always_ff @(posedge clk)
	begin
		// A calibration step is an ordinary write of zero
		if (state == mpmc_pkg::CALIB)
		begin
			cur_cmd.we <= 1'b1;
			cur_cmd.addr <= calib_addr;
			cur_cmd.wdata <= '0;
		end
		else if (take)
		begin
			cur_cmd <= fifo.head[grant_idx];
			cur_port <= grant_idx;
		end
		// Writes answer with zero data
		if (xfer_done)
		begin
			rsp_data <= cur_cmd.we ? '0 : prdata;
			rsp_err <= pslverr;
		end
	end

endmodule

// ==== hdl/mpmc_top.sv ====
module mpmc_top (
	input  logic                                 clk,
	input  logic                                 rst,
	// Client command streams
	input  logic [mpmc_pkg::NPORTS-1:0]          cmd_valid,
	output logic [mpmc_pkg::NPORTS-1:0]          cmd_ready,
	input  logic [mpmc_pkg::NPORTS-1:0]          cmd_we,
	input  logic [mpmc_pkg::NPORTS*mpmc_pkg::ADDR_W-1:0] cmd_addr,
	input  logic [mpmc_pkg::NPORTS*mpmc_pkg::DATA_W-1:0] cmd_wdata,
	// Client responses
	output logic [mpmc_pkg::NPORTS-1:0]          rsp_valid,
	output logic [mpmc_pkg::DATA_W-1:0]          rsp_data,
	output logic                                 rsp_err,
	// APB requester toward the memory
	output logic [mpmc_pkg::ADDR_W-1:0]          paddr,
	output logic                                 psel,
	output logic                                 penable,
	output logic                                 pwrite,
	output logic [mpmc_pkg::DATA_W-1:0]          pwdata,
	input  logic [mpmc_pkg::DATA_W-1:0]          prdata,
	input  logic                                 pready,
	input  logic                                 pslverr,
	output logic                                 calib_complete
);

	mpmc_fifo_if fifo_bus ();

	mpmc_pkg::mpmc_cmd_t         cmd_ent [mpmc_pkg::NPORTS];
	mpmc_pkg::mpmc_state_t       state;
	logic [mpmc_pkg::NPORTS-1:0] rd;
	logic [mpmc_pkg::NPORTS-1:0] grant;
	logic [mpmc_pkg::PORT_W-1:0] grant_idx;
	logic                        take;

	// ====================
	// Command FIFO bank
	// ====================

	for (genvar i = 0; i < mpmc_pkg::NPORTS; i++)
	begin : g_port
		// Slice the packed client buses into one entry per port
		assign cmd_ent[i].we = cmd_we[i];
		assign cmd_ent[i].addr = cmd_addr[i*mpmc_pkg::ADDR_W +: mpmc_pkg::ADDR_W];
		assign cmd_ent[i].wdata = cmd_wdata[i*mpmc_pkg::DATA_W +: mpmc_pkg::DATA_W];

		// Valid goes straight in as push; the FIFO qualifies it with ready
		mpmc_cmd_fifo u_cmd_fifo (
			.clk         (clk),
			.rst         (rst),
			.push        (cmd_valid[i]),
			.cmd         (cmd_ent[i]),
			.pop         (fifo_bus.pop[i]),
			.head        (fifo_bus.head[i]),
			.ready       (cmd_ready[i]),
			.empty       (fifo_bus.empty[i]),
			.rd_rst_busy (fifo_bus.rd_rst_busy[i])
		);
	end

	mpmc_rd_fifo_gen u_rd_fifo_gen (
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.empty          (fifo_bus.empty),
		.rd_rst_busy    (fifo_bus.rd_rst_busy),
		.calib_complete (calib_complete),
		.rd             (rd)
	);

	mpmc_port_sel u_port_sel (
		.clk       (clk),
		.rst       (rst),
		.rd        (rd),
		.take      (take),
		.grant     (grant),
		.grant_idx (grant_idx)
	);

	mpmc_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.fifo           (fifo_bus.ctrl_side),
		.rd             (rd),
		.grant          (grant),
		.grant_idx      (grant_idx),
		.take           (take),
		.state          (state),
		.calib_complete (calib_complete),
		.paddr          (paddr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.rsp_valid      (rsp_valid),
		.rsp_data       (rsp_data),
		.rsp_err        (rsp_err)
	);

endmodule

// ==== testbench/apb_mem_model.sv ====
// APB completer memory used as the controller's backing store
module apb_mem_model (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mpmc_pkg::ADDR_W-1:0] paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [mpmc_pkg::DATA_W-1:0] pwdata,
	output logic [mpmc_pkg::DATA_W-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr
);

	timeunit 1ns;
	timeprecision 1ps;

	// The top word answers every access with an error and is never written
	localparam logic [mpmc_pkg::ADDR_W-1:0] ERR_ADDR = '1;

	logic [mpmc_pkg::DATA_W-1:0] mem [2**mpmc_pkg::ADDR_W];
	logic [1:0]                  wait_cnt;
	logic [31:0]                 rnd;
	logic                        access;
	integer                      seed;

	// Before reset psel can be unknown, so the access phase is decoded strictly
	assign access = (psel === 1'b1) && (penable === 1'b1);
	assign pready = access && (wait_cnt == 2'd0);
	assign pslverr = access && (paddr == ERR_ADDR);
	assign prdata = (access && paddr != ERR_ADDR) ? mem[paddr] : '0;

	initial
	begin
		// Random contents, so only calibration can make the low words read zero
		seed = 32'hb561d71d;
		for (int i = 0; i < 2**mpmc_pkg::ADDR_W; i++)
			mem[i] = $random(seed);
		forever
		begin
			@(posedge clk);
			// A fresh wait of 0 to 3 cycles is drawn in every setup phase
			if (rst)
				wait_cnt <= 2'd0;
			else if (psel && !penable)
			begin
				rnd = $random(seed);
				wait_cnt <= rnd[1:0];
			end
			else if (access && !pready)
				wait_cnt <= wait_cnt - 2'd1;
			if (!rst && pready && pwrite && paddr != ERR_ADDR)
				mem[paddr] <= pwdata;
		end
	end

endmodule

// ==== testbench/mpmc_properties.sv ====
// Protocol checks on the controller's APB side and its client handshake
module mpmc_properties (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mpmc_pkg::NPORTS-1:0] cmd_ready,
	input  logic [mpmc_pkg::NPORTS-1:0] rsp_valid,
	input  logic [mpmc_pkg::ADDR_W-1:0] paddr,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pready
);

	timeunit 1ns;
	timeprecision 1ps;

	// A setup phase is always followed by the access phase
	setup_then_access: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable)
		else $error("APB setup phase was not followed by an access phase");

	// The address holds from setup until the completing cycle
	addr_stable: assert property (@(posedge clk) disable iff (rst)
		psel && !(penable && pready) |=> $stable(paddr))
		else $error("APB address changed before the transfer completed");

	// At most one client sees a response in any cycle
	rsp_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(rsp_valid))
		else $error("More than one rsp_valid bit is high");

	// The FIFOs refuse commands while reset is held
	ready_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> cmd_ready == '0)
		else $error("cmd_ready is high while rst is high");

endmodule

bind mpmc_top mpmc_properties u_mpmc_properties (
	.clk       (clk),
	.rst       (rst),
	.cmd_ready (cmd_ready),
	.rsp_valid (rsp_valid),
	.paddr     (paddr),
	.psel      (psel),
	.penable   (penable),
	.pready    (pready)
);

// ==== testbench/tb_mpmc.sv ====
module tb_mpmc;

	timeunit 1ns;
	timeprecision 1ps;

	// One stimulus row; sync holds the row back until all earlier commands are answered
	typedef struct packed {
		logic                        sync;
		logic [mpmc_pkg::PORT_W-1:0] port;
		logic                        we;
		logic [mpmc_pkg::ADDR_W-1:0] addr;
		logic [mpmc_pkg::DATA_W-1:0] wdata;
		logic [mpmc_pkg::DATA_W-1:0] exp_data;
		logic                        exp_err;
	} row_t;

	// Response a client expects for one accepted command
	typedef struct packed {
		logic                        err;
		logic [mpmc_pkg::DATA_W-1:0] data;
	} exp_t;

	localparam int NROWS = 26;

	// Reset, worst case calibration and a generous budget per row
	localparam int LIMIT_CYCLES = 2 + mpmc_pkg::CALIB_WORDS * 8 + NROWS * 20;

	localparam row_t ROWS [NROWS] = '{
		// The first 17 rows load every FIFO while calibration runs
		'{1'b0, 2'd0, 1'b1, 8'h20, 32'ha0a0_0001, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd1, 1'b1, 8'h21, 32'hb1b1_0002, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd2, 1'b1, 8'h22, 32'hc2c2_0003, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd3, 1'b1, 8'h23, 32'hd3d3_0004, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd0, 1'b0, 8'h20, 32'h0000_0000, 32'ha0a0_0001, 1'b0},
		'{1'b0, 2'd1, 1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd2, 1'b0, 8'h22, 32'h0000_0000, 32'hc2c2_0003, 1'b0},
		'{1'b0, 2'd3, 1'b0, 8'h0f, 32'h0000_0000, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd0, 1'b0, 8'h03, 32'h0000_0000, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd1, 1'b0, 8'h21, 32'h0000_0000, 32'hb1b1_0002, 1'b0},
		'{1'b0, 2'd2, 1'b0, 8'h07, 32'h0000_0000, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd3, 1'b0, 8'h23, 32'h0000_0000, 32'hd3d3_0004, 1'b0},
		'{1'b0, 2'd0, 1'b1, 8'h24, 32'h0000_5a5a, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd1, 1'b1, 8'h25, 32'h1234_5678, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd2, 1'b0, 8'h0a, 32'h0000_0000, 32'h0000_0000, 1'b0},
		'{1'b0, 2'd3, 1'b0, 8'h0c, 32'h0000_0000, 32'h0000_0000, 1'b0},
		// Fifth command on port 0 stalls on a full FIFO
		'{1'b0, 2'd0, 1'b0, 8'h24, 32'h0000_0000, 32'h0000_5a5a, 1'b0},
		// Reads across ports, then the error word
		'{1'b1, 2'd2, 1'b0, 8'h20, 32'h0000_0000, 32'ha0a0_0001, 1'b0},
		'{1'b0, 2'd3, 1'b0, 8'h25, 32'h0000_0000, 32'h1234_5678, 1'b0},
		'{1'b0, 2'd1, 1'b1, 8'h05, 32'hcafe_f00d, 32'h0000_0000, 1'b0},
		'{1'b1, 2'd3, 1'b0, 8'h05, 32'h0000_0000, 32'hcafe_f00d, 1'b0},
		'{1'b0, 2'd3, 1'b0, 8'hff, 32'h0000_0000, 32'h0000_0000, 1'b1},
		'{1'b0, 2'd1, 1'b1, 8'hff, 32'hdead_beef, 32'h0000_0000, 1'b1},
		'{1'b0, 2'd2, 1'b0, 8'h21, 32'h0000_0000, 32'hb1b1_0002, 1'b0},
		'{1'b0, 2'd0, 1'b1, 8'h30, 32'h8765_4321, 32'h0000_0000, 1'b0},
		'{1'b1, 2'd1, 1'b0, 8'h30, 32'h0000_0000, 32'h8765_4321, 1'b0}
	};

	logic                                         clk;
	logic                                         rst;
	logic [mpmc_pkg::NPORTS-1:0]                  cmd_valid;
	logic [mpmc_pkg::NPORTS-1:0]                  cmd_ready;
	logic [mpmc_pkg::NPORTS-1:0]                  cmd_we;
	logic [mpmc_pkg::NPORTS*mpmc_pkg::ADDR_W-1:0] cmd_addr;
	logic [mpmc_pkg::NPORTS*mpmc_pkg::DATA_W-1:0] cmd_wdata;
	logic [mpmc_pkg::NPORTS-1:0]                  rsp_valid;
	logic [mpmc_pkg::DATA_W-1:0]                  rsp_data;
	logic                                         rsp_err;
	logic [mpmc_pkg::ADDR_W-1:0]                  paddr;
	logic                                         psel;
	logic                                         penable;
	logic                                         pwrite;
	logic [mpmc_pkg::DATA_W-1:0]                  pwdata;
	logic [mpmc_pkg::DATA_W-1:0]                  prdata;
	logic                                         pready;
	logic                                         pslverr;
	logic                                         calib_complete;

	// ====================
	// Scoreboard state
	// ====================

	// Expected responses per port, in command order
	exp_t exp_q [mpmc_pkg::NPORTS][$];
	exp_t drive_exp [mpmc_pkg::NPORTS];

	// Bit q of waiting[p] is set while port q still owes a turn before p's next one
	logic [mpmc_pkg::NPORTS-1:0] waiting [mpmc_pkg::NPORTS] = '{default: '0};

	int   checks = 0;
	int   mismatches = 0;
	int   failures = 0;
	logic full_seen = 1'b0;

	mpmc_top u_mpmc_top (.*);

	apb_mem_model u_apb_mem_model (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int pending_total();
		int n;
		n = 0;
		for (int p = 0; p < mpmc_pkg::NPORTS; p++)
			n += exp_q[p].size();
		return n;
	endfunction

	// Presents one row on its port and returns on the edge that accepts it
	task automatic send_row(input row_t r);
		cmd_valid[r.port] <= 1'b1;
		cmd_we[r.port] <= r.we;
		cmd_addr[int'(r.port) * mpmc_pkg::ADDR_W +: mpmc_pkg::ADDR_W] <= r.addr;
		cmd_wdata[int'(r.port) * mpmc_pkg::DATA_W +: mpmc_pkg::DATA_W] <= r.wdata;
		drive_exp[r.port] <= '{err: r.exp_err, data: r.exp_data};
		@(negedge clk);
		while (!cmd_ready[r.port])
			@(negedge clk);
		@(posedge clk);
		cmd_valid[r.port] <= 1'b0;
	endtask

	// ====================
	// Monitor
	// ====================

	// Everything is sampled mid-cycle, where registered outputs have settled
	always @(negedge clk)
	begin
		exp_t want;
		if (rst)
		begin
			assert (cmd_ready == '0 && !psel && rsp_valid == '0)
			else
			begin
				$display("At %0t ns an output is active while rst is high", $time);
				failures++;
			end
		end
		else
		begin
			for (int p = 0; p < mpmc_pkg::NPORTS; p++)
			begin
				if (rsp_valid[p])
				begin
					checks++;
					assert (calib_complete)
					else
					begin
						$display("At %0t ns port %0d got a response during calibration", $time, p);
						failures++;
					end
					assert (exp_q[p].size() != 0)
					else
					begin
						$display("At %0t ns port %0d got a response it never asked for", $time, p);
						failures++;
					end
					if (exp_q[p].size() != 0)
					begin
						want = exp_q[p].pop_front();
						assert (rsp_data == want.data)
						else
						begin
							$display("MISMATCH %0t ns rsp_data port %0d expected %h got %h",
								$time, p, want.data, rsp_data);
							mismatches++;
						end
						assert (rsp_err == want.err)
						else
						begin
							$display("MISMATCH %0t ns rsp_err port %0d expected %b got %b",
								$time, p, want.err, rsp_err);
							mismatches++;
						end
						assert (waiting[p] == '0)
						else
						begin
							$display("At %0t ns port %0d was served again while ports %b waited",
								$time, p, waiting[p]);
							failures++;
						end
						// This response settles p's debt and starts a new round for p
						for (int q = 0; q < mpmc_pkg::NPORTS; q++)
						begin
							waiting[q][p] = 1'b0;
							waiting[p][q] = (q != p) && (exp_q[q].size() != 0);
						end
					end
				end
				// Nothing is popped before calibration ends, so the queue length is the fill
				if (!calib_complete && exp_q[p].size() == mpmc_pkg::FIFO_DEPTH)
				begin
					full_seen = 1'b1;
					assert (!cmd_ready[p])
					else
					begin
						$display("MISMATCH %0t ns cmd_ready[%0d] expected 0 got 1", $time, p);
						mismatches++;
					end
				end
				// Valid with ready now means a transfer on the next rising edge
				if (cmd_valid[p] && cmd_ready[p])
					exp_q[p].push_back(drive_exp[p]);
			end
		end
	end

	initial
	begin
		rst <= 1'b1;
		cmd_valid <= '0;
		cmd_we <= '0;
		cmd_addr <= '0;
		cmd_wdata <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < NROWS; i++)
		begin
			if (ROWS[i].sync)
			begin
				while (pending_total() != 0)
					@(posedge clk);
			end
			send_row(ROWS[i]);
		end
		while (pending_total() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		assert (full_seen)
		else
		begin
			$display("No FIFO filled up while calibration was running");
			failures++;
		end
		$display("Responses checked %0d, mismatches %0d, other errors %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timed out after %0d cycles with %0d responses outstanding",
			LIMIT_CYCLES, pending_total());
		$display("test failed");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/mpmc_pkg.sv
hdl/mpmc_fifo_if.sv
hdl/mpmc_cmd_fifo.sv
hdl/mpmc_rd_fifo_gen.sv
hdl/mpmc_port_sel.sv
hdl/mpmc_ctrl.sv
hdl/mpmc_top.sv
testbench/apb_mem_model.sv
testbench/mpmc_properties.sv
testbench/tb_mpmc.sv

// ==== Makefile ====
# Verilator build and run of the mpmc testbench
TOP := tb_mpmc
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)

# The run fails if the log reports failure or never reports a pass
run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
